//--- filelist.f
+incdir+.
bpred_pkg.sv
btb_storage.sv
btb_lookup.sv
btb_update.sv
btb_flush_ctrl.sv
branch_predictor.sv
tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the branch predictor testbench with Verilator.
# The exit status is that of the simulation: non-zero on any failure.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_branch_predictor -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

//--- tb_branch_predictor.sv
/* self-checking testbench for the BTB predictor; a model of every set runs beside the DUT
   outputs are compared each falling edge; first mismatch or the cycle limit ends the run */

`include "bpred_macros.svh"

module tb_branch_predictor;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int IDXB = $clog2(`BTB_N_SETS);
	localparam int TAGB = `BTB_TAG_BITS;
	localparam logic [IDXB-1:0] LAST_IDX = IDXB'(`BTB_N_SETS - 1);
	localparam int CYCLE_LIMIT = 4000; // 1500 random + ~300 directed + sweeps, with margin
	localparam logic [31:0] PC_A = 32'h0000_1040; // idx 0, tag 1
	localparam logic [31:0] PC_B = 32'h0000_1080; // idx 0, tag 2
	localparam logic [31:0] PC_C = 32'h0000_10c0; // idx 0, tag 3
	localparam logic [31:0] T_A = 32'h0000_2000;
	localparam logic [31:0] T_B = 32'h0000_3000;
	localparam logic [31:0] T_C = 32'h0000_4000;

	logic CLK, nRST, is_branch, is_rv32c, update_predictor, branch_result, flush;
	logic [31:0] current_pc, pc_to_update, update_addr;
	logic predict_taken, busy;
	logic [31:0] target_addr;

	logic m_valid [`BTB_N_SETS][2];         // reference copy of the sets
	logic [TAGB-1:0] m_tag [`BTB_N_SETS][2];
	logic [31:0] m_target [`BTB_N_SETS][2];
	logic [1:0] m_ctr [`BTB_N_SETS][2];
	logic m_busy;
	logic [IDXB-1:0] m_cnt;                  // set the model clears next
	logic [32:0] exp_pred;
	logic [31:0] r;
	integer seed;
	int cycles;
	int count;

	branch_predictor i_branch_predictor (.CLK, .nRST, .current_pc, .is_branch, .is_rv32c,
		.predict_taken, .target_addr, .update_predictor, .pc_to_update, .update_addr,
		.branch_result, .flush, .busy);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, got);
		$display("Testbench failed");
		$fatal(1, "value mismatch");
	endtask

	// {taken, next fetch address} from the model
	function automatic logic [32:0] ref_predict(input logic [31:0] pc, input logic br,
		input logic c);
		logic [IDXB-1:0] idx;
		logic [TAGB-1:0] tag;
		logic taken;
		logic [31:0] tgt;
		idx = pc[2 +: IDXB];
		tag = pc[2 + IDXB +: TAGB];
		taken = 1'b0;
		tgt = pc + (c ? 32'd2 : 32'd4); // fall through
		if (br && !m_busy) begin
			if (m_valid[idx][0] && m_tag[idx][0] == tag) begin // way 0 first
				taken = m_ctr[idx][0][1];
				if (taken) tgt = m_target[idx][0];
			end else if (m_valid[idx][1] && m_tag[idx][1] == tag) begin
				taken = m_ctr[idx][1][1];
				if (taken) tgt = m_target[idx][1];
			end
		end
		return {taken, tgt};
	endfunction

	task automatic model_train(input logic [31:0] pc, input logic [31:0] addr, input logic res);
		logic [IDXB-1:0] idx;
		logic [TAGB-1:0] tag;
		logic way;
		logic [1:0] c;
		idx = pc[2 +: IDXB];
		tag = pc[2 + IDXB +: TAGB];
		c = 2'b00; // fresh entry starts strongly not taken
		if (m_valid[idx][0] && m_tag[idx][0] == tag) begin
			way = 1'b0;
			c = m_ctr[idx][0];
		end else if (m_valid[idx][1] && m_tag[idx][1] == tag) begin
			way = 1'b1;
			c = m_ctr[idx][1];
		end else begin
			way = m_valid[idx][0]; // free way 0, else way 1
		end
		case (c)
			2'b00: c = res ? 2'b01 : 2'b00;
			2'b01: c = res ? 2'b11 : 2'b00;
			2'b10: c = res ? 2'b11 : 2'b00;
			default: c = res ? 2'b11 : 2'b10;
		endcase
		m_valid[idx][way] = 1'b1;
		m_tag[idx][way] = tag;
		m_target[idx][way] = addr;
		m_ctr[idx][way] = c;
	endtask

	// model steps on the same edge as the DUT, inputs are stable there
	always @(posedge CLK) begin
		if (!nRST) begin
			for (int s = 0; s < `BTB_N_SETS; s++) begin
				for (int w = 0; w < 2; w++) m_valid[s][w] = 1'b0;
			end
			m_busy = 1'b0;
			m_cnt = '0;
		end else if (m_busy) begin
			for (int w = 0; w < 2; w++) m_valid[m_cnt][w] = 1'b0; // sweep drops updates
			if (m_cnt == LAST_IDX) m_busy = 1'b0;
			m_cnt = m_cnt + 1'b1;
		end else begin
			if (update_predictor) model_train(pc_to_update, update_addr, branch_result);
			if (flush) begin
				m_busy = 1'b1;
				m_cnt = '0;
			end
		end
	end

	always @(negedge CLK) begin
		if (nRST) begin
			exp_pred = ref_predict(current_pc, is_branch, is_rv32c);
			assert (predict_taken === exp_pred[32])
				else report_value("predict_taken", {31'b0, exp_pred[32]}, {31'b0, predict_taken});
			assert (target_addr === exp_pred[31:0])
				else report_value("target_addr", exp_pred[31:0], target_addr);
			assert (busy === m_busy) else report_value("busy", {31'b0, m_busy}, {31'b0, busy});
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$fatal(1, "timeout");
		end
	end

	task automatic next_cycle();
		@(posedge CLK);
		#2; // drive just after the edge
	endtask

	task automatic set_fetch(input logic [31:0] pc, input logic br, input logic c);
		current_pc = pc;
		is_branch = br;
		is_rv32c = c;
	endtask

	task automatic drive_update(input logic [31:0] pc, input logic [31:0] addr, input logic res);
		update_predictor = 1'b1;
		pc_to_update = pc;
		update_addr = addr;
		branch_result = res;
		next_cycle();
		update_predictor = 1'b0;
	endtask

	// directed spot check against values from the training rules
	task automatic expect_pred(input logic t, input logic [31:0] tgt);
		#1;
		assert (predict_taken === t) else report_value("predict_taken", {31'b0, t},
			{31'b0, predict_taken});
		assert (target_addr === tgt) else report_value("target_addr", tgt, target_addr);
	endtask

	// small pool: idx 0..3, tag low bits vary, bits 16-17 alias onto the same entries
	function automatic logic [31:0] pick_pc();
		return 32'h0000_1000 | ($random(seed) & 32'h0003_00ce);
	endfunction

	initial begin
		seed = 32'h015e_21ac;
		cycles = 0;
		nRST = 1'b0;
		set_fetch(32'h0, 1'b0, 1'b0);
		update_predictor = 1'b0;
		pc_to_update = '0;
		update_addr = '0;
		branch_result = 1'b0;
		flush = 1'b0;
		repeat (4) @(posedge CLK);
		#2 nRST = 1'b1;

		for (int i = 0; i < 4; i++) begin // empty after reset
			set_fetch(PC_A + 32'(i * 64), 1'b1, i[0]);
			expect_pred(1'b0, PC_A + 32'(i * 64) + (i[0] ? 32'd2 : 32'd4));
			next_cycle();
		end

		set_fetch(PC_A, 1'b1, 1'b0); // hysteresis on one entry
		drive_update(PC_A, T_A, 1'b1);
		expect_pred(1'b0, PC_A + 32'd4);
		drive_update(PC_A, T_A, 1'b1);
		expect_pred(1'b1, T_A);
		drive_update(PC_A, T_A, 1'b0);
		expect_pred(1'b1, T_A); // weakly taken holds
		drive_update(PC_A, T_A, 1'b0);
		expect_pred(1'b0, PC_A + 32'd4);
		drive_update(PC_A, T_A, 1'b1);
		drive_update(PC_A, T_A, 1'b1);
		expect_pred(1'b1, T_A);
		is_branch = 1'b0;
		expect_pred(1'b0, PC_A + 32'd4);

		drive_update(PC_B, T_B, 1'b1); // same set, way 1
		drive_update(PC_B, T_B, 1'b1);
		set_fetch(PC_B, 1'b1, 1'b0);
		expect_pred(1'b1, T_B);
		set_fetch(PC_A, 1'b1, 1'b0);
		expect_pred(1'b1, T_A);
		drive_update(PC_C, T_C, 1'b1); // evicts PC_B from way 1
		drive_update(PC_C, T_C, 1'b1);
		set_fetch(PC_C, 1'b1, 1'b0);
		expect_pred(1'b1, T_C);
		set_fetch(PC_B, 1'b1, 1'b0);
		expect_pred(1'b0, PC_B + 32'd4);
		set_fetch(PC_A, 1'b1, 1'b0);
		expect_pred(1'b1, T_A);

		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		assert (busy === 1'b1) else report_value("busy", 32'd1, {31'b0, busy});
		count = 0;
		while (busy) begin
			count++;
			update_predictor = (count == 2 || count == 3); // two taken strobes, both dropped
			pc_to_update = PC_B;
			update_addr = T_B;
			branch_result = 1'b1;
			flush = (count == 5); // ignored mid sweep
			next_cycle();
		end
		update_predictor = 1'b0;
		flush = 1'b0;
		assert (count == `BTB_N_SETS) else report_value("busy cycles", `BTB_N_SETS, count);
		expect_pred(1'b0, PC_A + 32'd4);
		set_fetch(PC_B, 1'b1, 1'b0);
		expect_pred(1'b0, PC_B + 32'd4);
		set_fetch(PC_C, 1'b1, 1'b0);
		expect_pred(1'b0, PC_C + 32'd4);

		for (int i = 0; i < 1500; i++) begin // random mix, checked by the model
			r = $random(seed);
			set_fetch(pick_pc(), r[0] | r[1], r[2]);
			update_predictor = r[3];
			pc_to_update = pick_pc();
			update_addr = $random(seed);
			branch_result = r[4] | r[5]; // mostly taken
			flush = (r[15:8] == 8'h00);
			next_cycle();
		end
		update_predictor = 1'b0;
		flush = 1'b0;
		repeat (2) next_cycle();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- branch_predictor.sv
/* two way BTB predictor top; fetch lookup is combinational, training lands next cycle
   flush clears one set per cycle with busy high, no handshakes anywhere */

module branch_predictor (
	input  logic             CLK,
	input  logic             nRST,
	input  bpred_pkg::word_t current_pc,
	input  logic             is_branch,
	input  logic             is_rv32c,
	output logic             predict_taken,
	output bpred_pkg::word_t target_addr,
	input  logic             update_predictor,
	input  bpred_pkg::word_t pc_to_update,
	input  bpred_pkg::word_t update_addr,
	input  logic             branch_result,
	input  logic             flush,
	output logic             busy
);
	import bpred_pkg::*;

	btb_idx_t   rd_idx_a, rd_idx_b, wr_idx, sweep_idx;
	logic       wr_en;
	logic       rd_valid_a [2], rd_valid_b [2], wr_valid [2];
	btb_tag_t   rd_tag_a [2], rd_tag_b [2], wr_tag [2];
	word_t      rd_target_a [2], rd_target_b [2], wr_target [2];
	dir_state_t rd_ctr_a [2], rd_ctr_b [2], wr_ctr [2];

	btb_storage i_btb_storage (.CLK, .nRST, .rd_idx_a, .rd_idx_b, .wr_en, .wr_idx,
		.wr_valid, .wr_tag, .wr_target, .wr_ctr,
		.rd_valid_a, .rd_tag_a, .rd_target_a, .rd_ctr_a,
		.rd_valid_b, .rd_tag_b, .rd_target_b, .rd_ctr_b);

	// fetch side, reads port a
	btb_lookup i_btb_lookup (.current_pc, .is_branch, .is_rv32c, .busy,
		.rd_valid_a, .rd_tag_a, .rd_target_a, .rd_ctr_a,
		.rd_idx_a, .predict_taken, .target_addr);

	// execute side training and sweep writes, reads port b
	btb_update i_btb_update (.update_predictor, .pc_to_update, .update_addr,
		.branch_result, .busy, .sweep_idx,
		.rd_valid_b, .rd_tag_b, .rd_target_b, .rd_ctr_b,
		.rd_idx_b, .wr_en, .wr_idx, .wr_valid, .wr_tag, .wr_target, .wr_ctr);

	btb_flush_ctrl i_btb_flush_ctrl (.CLK, .nRST, .flush, .busy, .sweep_idx);

endmodule

//--- btb_flush_ctrl.sv
/* flush sweep, busy for exactly BTB_N_SETS cycles starting the edge after flush
   a flush strobe seen while sweeping is ignored */

`include "bpred_macros.svh"

module btb_flush_ctrl (
	input  logic                CLK,
	input  logic                nRST,
	input  logic                flush,
	output logic                busy,
	output bpred_pkg::btb_idx_t sweep_idx
);
	import bpred_pkg::*;

	localparam btb_idx_t LAST_IDX = btb_idx_t'(`BTB_N_SETS - 1);

	flush_state_t state_q;
	btb_idx_t     cnt_q; // set being cleared

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q <= fl_idle;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				fl_idle: begin
					if (flush) begin
						state_q <= fl_sweep;
						cnt_q   <= '0; // start from set 0
					end
				end
				fl_sweep: begin
					cnt_q <= cnt_q + btb_idx_t'(1);
					if (cnt_q == LAST_IDX) begin
						state_q <= fl_idle; // last set written this edge
					end
				end
				default: begin
					state_q <= fl_idle;
				end
			endcase
		end
	end

	assign busy      = (state_q == fl_sweep);
	assign sweep_idx = cnt_q;

	// a sweep never ends early
	a_busy_fall_last: assert property (@(posedge CLK) disable iff (!nRST)
		$fell(busy) |-> ($past(sweep_idx) == LAST_IDX))
		else $error("btb_flush_ctrl: busy dropped before the last set");

endmodule

//--- btb_update.sv
/* training write path, one resolved branch per cycle, victim is always way 1
   during a flush sweep the update strobe is dropped and an empty set is written */

`include "bpred_macros.svh"

module btb_update (
	input  logic                  update_predictor,
	input  bpred_pkg::word_t      pc_to_update,
	input  bpred_pkg::word_t      update_addr,
	input  logic                  branch_result,
	input  logic                  busy,
	input  bpred_pkg::btb_idx_t   sweep_idx,
	input  logic                  rd_valid_b [2],
	input  bpred_pkg::btb_tag_t   rd_tag_b [2],
	input  bpred_pkg::word_t      rd_target_b [2],
	input  bpred_pkg::dir_state_t rd_ctr_b [2],
	output bpred_pkg::btb_idx_t   rd_idx_b,
	output logic                  wr_en,
	output bpred_pkg::btb_idx_t   wr_idx,
	output logic                  wr_valid [2],
	output bpred_pkg::btb_tag_t   wr_tag [2],
	output bpred_pkg::word_t      wr_target [2],
	output bpred_pkg::dir_state_t wr_ctr [2]
);
	import bpred_pkg::*;

	btb_tag_t   upd_tag;
	logic [1:0] match;    // per way tag hit
	logic       way_sel;  // way being trained
	dir_state_t base_ctr;
	dir_state_t next_ctr;
	logic [1:0] way_diff; // ways that change on this write

	function automatic dir_state_t next_dir(input dir_state_t cur, input logic taken);
		case (cur)
			ctr_snt: next_dir = taken ? ctr_wnt : ctr_snt;
			ctr_wnt: next_dir = taken ? ctr_st : ctr_snt;
			ctr_wt:  next_dir = taken ? ctr_st : ctr_snt;
			default: next_dir = taken ? ctr_st : ctr_wt; // ctr_st
		endcase
	endfunction

	assign rd_idx_b = pc_to_update[IDX_LSB +: BTB_IDX_BITS];
	assign upd_tag  = pc_to_update[TAG_LSB +: `BTB_TAG_BITS];

	assign match[0] = rd_valid_b[0] && (rd_tag_b[0] == upd_tag);
	assign match[1] = rd_valid_b[1] && (rd_tag_b[1] == upd_tag);

	// matching way, else free way 0, else way 1 (free or victim)
	always_comb begin
		if (match[0])
			way_sel = 1'b0;
		else if (match[1])
			way_sel = 1'b1;
		else if (!rd_valid_b[0])
			way_sel = 1'b0;
		else
			way_sel = 1'b1;
	end

	// new allocation trains from strongly not taken
	assign base_ctr = (match != 2'b00) ? rd_ctr_b[way_sel] : ctr_snt;
	assign next_ctr = next_dir(base_ctr, branch_result);

	always_comb begin
		wr_en  = 1'b0;
		wr_idx = rd_idx_b;
		for (int w = 0; w < 2; w++) begin // default keep set as read
			wr_valid[w]  = rd_valid_b[w];
			wr_tag[w]    = rd_tag_b[w];
			wr_target[w] = rd_target_b[w];
			wr_ctr[w]    = rd_ctr_b[w];
		end
		if (busy) begin
			wr_en  = 1'b1;
			wr_idx = sweep_idx; // clear the swept set
			for (int w = 0; w < 2; w++) begin
				wr_valid[w]  = 1'b0;
				wr_tag[w]    = '0;
				wr_target[w] = '0;
				wr_ctr[w]    = ctr_snt;
			end
		end else if (update_predictor) begin
			wr_en             = 1'b1;
			wr_valid[way_sel]  = 1'b1;
			wr_tag[way_sel]    = upd_tag;
			wr_target[way_sel] = update_addr; // target always refreshed
			wr_ctr[way_sel]    = next_ctr;
		end
	end

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_diff[w] = (wr_valid[w] != rd_valid_b[w]) || (wr_tag[w] != rd_tag_b[w])
				|| (wr_target[w] != rd_target_b[w]) || (wr_ctr[w] != rd_ctr_b[w]);
		end
	end

	// a training write touches one way of the stored set, never both
	always_comb begin
		if (wr_en && !busy) begin
			assert final ($countones(way_diff) <= 1)
				else $error("btb_update: training write changed both ways");
		end
	end

endmodule

//--- btb_lookup.sv
/* zero cycle prediction from the registered set at the fetch index
   way 0 wins a double hit; while busy the fall-through address is returned */

`include "bpred_macros.svh"

module btb_lookup (
	input  bpred_pkg::word_t      current_pc,
	input  logic                  is_branch,
	input  logic                  is_rv32c,
	input  logic                  busy,
	input  logic                  rd_valid_a [2],
	input  bpred_pkg::btb_tag_t   rd_tag_a [2],
	input  bpred_pkg::word_t      rd_target_a [2],
	input  bpred_pkg::dir_state_t rd_ctr_a [2],
	output bpred_pkg::btb_idx_t   rd_idx_a,
	output logic                  predict_taken,
	output bpred_pkg::word_t      target_addr
);
	import bpred_pkg::*;

	btb_tag_t   pc_tag;
	logic       hit0;
	logic       hit1;
	logic       any_hit;
	dir_state_t hit_ctr;
	word_t      hit_target;
	word_t      fall_through;

	// split pc into index and tag
	assign rd_idx_a = current_pc[IDX_LSB +: BTB_IDX_BITS];
	assign pc_tag   = current_pc[TAG_LSB +: `BTB_TAG_BITS];

	// only valid ways can hit
	assign hit0    = rd_valid_a[0] && (rd_tag_a[0] == pc_tag);
	assign hit1    = rd_valid_a[1] && (rd_tag_a[1] == pc_tag);
	assign any_hit = hit0 || hit1;

	// way 0 has priority
	assign hit_ctr    = hit0 ? rd_ctr_a[0] : rd_ctr_a[1];
	assign hit_target = hit0 ? rd_target_a[0] : rd_target_a[1];

	// compressed instr is 2 bytes
	assign fall_through = current_pc + (is_rv32c ? word_t'(2) : word_t'(4));

	always_comb begin
		predict_taken = 1'b0; // miss or sweep in progress
		if (any_hit && is_branch && !busy) begin
			predict_taken = hit_ctr[1]; // counter msb
		end
		target_addr = predict_taken ? hit_target : fall_through;
	end

endmodule

//--- btb_storage.sv
/* BTB_N_SETS x 2 way entry array, whole set written per cycle
   two combinational read ports, everything cleared by nRST */

`include "bpred_macros.svh"

module btb_storage (
	input  logic                    CLK,
	input  logic                    nRST,
	input  bpred_pkg::btb_idx_t     rd_idx_a,
	input  bpred_pkg::btb_idx_t     rd_idx_b,
	input  logic                    wr_en,
	input  bpred_pkg::btb_idx_t     wr_idx,
	input  logic                    wr_valid [2],
	input  bpred_pkg::btb_tag_t     wr_tag [2],
	input  bpred_pkg::word_t        wr_target [2],
	input  bpred_pkg::dir_state_t   wr_ctr [2],
	output logic                    rd_valid_a [2],
	output bpred_pkg::btb_tag_t     rd_tag_a [2],
	output bpred_pkg::word_t        rd_target_a [2],
	output bpred_pkg::dir_state_t   rd_ctr_a [2],
	output logic                    rd_valid_b [2],
	output bpred_pkg::btb_tag_t     rd_tag_b [2],
	output bpred_pkg::word_t        rd_target_b [2],
	output bpred_pkg::dir_state_t   rd_ctr_b [2]
);
	import bpred_pkg::*;

	logic       valid_q  [`BTB_N_SETS][2];
	btb_tag_t   tag_q    [`BTB_N_SETS][2];
	word_t      target_q [`BTB_N_SETS][2];
	dir_state_t ctr_q    [`BTB_N_SETS][2];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < `BTB_N_SETS; s++) begin
				for (int w = 0; w < 2; w++) begin
					valid_q[s][w]  <= 1'b0; // all entries empty
					tag_q[s][w]    <= '0;
					target_q[s][w] <= '0;
					ctr_q[s][w]    <= ctr_snt;
				end
			end
		end else if (wr_en) begin
			for (int w = 0; w < 2; w++) begin // both ways of one set
				valid_q[wr_idx][w]  <= wr_valid[w];
				tag_q[wr_idx][w]    <= wr_tag[w];
				target_q[wr_idx][w] <= wr_target[w];
				ctr_q[wr_idx][w]    <= wr_ctr[w];
			end
		end
	end

	// port a feeds lookup, port b feeds update
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			rd_valid_a[w]  = valid_q[rd_idx_a][w];
			rd_tag_a[w]    = tag_q[rd_idx_a][w];
			rd_target_a[w] = target_q[rd_idx_a][w];
			rd_ctr_a[w]    = ctr_q[rd_idx_a][w];
			rd_valid_b[w]  = valid_q[rd_idx_b][w];
			rd_tag_b[w]    = tag_q[rd_idx_b][w];
			rd_target_b[w] = target_q[rd_idx_b][w];
			rd_ctr_b[w]    = ctr_q[rd_idx_b][w];
		end
	end

	// index from update or sweep logic must be clean when writing
	a_wr_idx_known: assert property (@(posedge CLK) disable iff (!nRST)
		wr_en |-> !$isunknown(wr_idx))
		else $error("btb_storage: write index has unknown bits");

endmodule

//--- bpred_pkg.sv
/* shared types of the predictor; index width follows BTB_N_SETS through clog2
   index starts at PC bit 2, tag sits right above the index */

`include "bpred_macros.svh"

package bpred_pkg;

	localparam int BTB_IDX_BITS = $clog2(`BTB_N_SETS);
	localparam int IDX_LSB      = 2;                    // skip byte offset
	localparam int TAG_LSB      = IDX_LSB + BTB_IDX_BITS;

	typedef logic [`WORD_SIZE-1:0]    word_t;          // pc or target
	typedef logic [BTB_IDX_BITS-1:0]  btb_idx_t;       // set select
	typedef logic [`BTB_TAG_BITS-1:0] btb_tag_t;       // partial tag

	// two bit direction counter, msb is the prediction
	typedef enum logic [1:0] {
		ctr_snt = 2'b00, // strongly not taken
		ctr_wnt = 2'b01, // weakly not taken
		ctr_wt  = 2'b10, // weakly taken
		ctr_st  = 2'b11  // strongly taken
	} dir_state_t;

	// flush sweep control
	typedef enum logic {
		fl_idle  = 1'b0,
		fl_sweep = 1'b1
	} flush_state_t;

endpackage

//--- bpred_macros.svh
/* sizing for the branch target buffer; BTB_N_SETS must be a power of two, 2 or more
   tag bits sit just above the index, higher PC bits are dropped so aliasing can happen */

`ifndef BPRED_MACROS_SVH
`define BPRED_MACROS_SVH

// PC and target width
`define WORD_SIZE 32

// sets in the buffer, two ways each
`define BTB_N_SETS 16

// 8 bits per entry minus the 2 counter bits
`define BTB_TAG_BITS 6

`endif
